/* rtl/cpuDataPkg.sv */
`include "cpu_defs.svh"

package cpuDataPkg;

  typedef logic [`CPU_DATA_W-1:0] byteT;
  typedef logic [`CPU_ADDR_W-1:0] wordT;
  typedef logic [`IRQ_W-1:0]      irqT;

  typedef struct packed
  {
    logic       we;
    logic [2:0] regCode;   // Opcode register code
    byteT       data;
  } regWriteT;

  typedef struct packed
  {
    logic load;
    wordT target;
  } pcLoadT;

endpackage

/* rtl/cpuMicroPkg.sv */
`include "cpu_defs.svh"

package cpuMicroPkg;

  typedef logic [`UPC_W-1:0] uPcT;

  typedef enum logic [3:0]
  {
    cmdNop,
    cmdSma,     // Latch a new bus address
    cmdSrm,     // Bus byte into a register
    cmdSmw,
    cmdAluOp,   // Register copy, AND or XOR
    cmdJint,    // Interrupt check point
    cmdSeti,
    cmdCeti
  } uOpCmdT;

  // Codes 0 to 7 follow the opcode register field
  typedef enum logic [3:0]
  {
    regB     = 4'd0,
    regC     = 4'd1,
    regD     = 4'd2,
    regE     = 4'd3,
    regH     = 4'd4,
    regL     = 4'd5,
    regHl    = 4'd6,
    regA     = 4'd7,
    regPc    = 4'd8,
    regOpSrc = 4'd9,    // Opcode bits 2..0
    regOpDst = 4'd10    // Opcode bits 5..3
  } regSelT;

  typedef struct packed
  {
    uOpCmdT cmd;
    regSelT operand;
    logic   incPc;
    logic   endFlow;
  } microOpT;

  typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} seqStateT;

endpackage

/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and sequencer widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16
`define UPC_W      6
`define IRQ_W      4

`define RESET_PC 16'h0000

// Interrupt targets, indexed by request bit
`define INT_VEC_VBLANK 16'h0040
`define INT_VEC_LCD    16'h0048
`define INT_VEC_TIMER  16'h0050
`define INT_VEC_JOYPAD 16'h0060

// Entry points of the microcode flows
`define FLOW_NOP  6'd0
`define FLOW_LDRN 6'd3
`define FLOW_ALU  6'd7
`define FLOW_STHL 6'd10
`define FLOW_EI   6'd14
`define FLOW_DI   6'd17

`endif

/* rtl/dzCpu.sv */
`timescale 1ns/1ps

module dzCpu
(
  input  logic             iClock,
  input  logic             rstN,
  input  cpuDataPkg::byteT iMcuData,
  output cpuDataPkg::byteT oMcuData,
  output cpuDataPkg::wordT oMcuAddr,
  output logic             oMcuReadRequest,
  output logic             oMcuWe,
  input  cpuDataPkg::irqT  iInterruptRequests
);
  import cpuMicroPkg::*;
  import cpuDataPkg::*;

  uPcT      uPc;
  microOpT  uOp;
  byteT     opcode;
  byteT     srcData;
  byteT     accData;
  wordT     irqVector;
  regSelT   srcSel;
  regSelT   addrSel;
  regWriteT regWrite;
  pcLoadT   pcLoad;
  logic     flowEnable;
  logic     addrSelLoad;
  logic     readStrobe;
  logic     imeWrite;
  logic     imeValue;
  logic     irqClear;
  logic     irqTaken;

  // --------------------
  microSequencer seq0 (.iClock, .rstN, .iMcuData, .endFlow(uOp.endFlow), .uPc, .flowEnable,
                       .opcode);

  microcodeRom rom0 (.uPc, .uOp);

  microOpExecute exe0 (.uOp, .flowEnable, .opcode, .iMcuData, .srcData, .accData, .irqTaken,
                       .irqVector, .srcSel, .regWrite, .pcLoad, .addrSelLoad, .addrSel,
                       .memWrite(oMcuWe), .readStrobe, .imeWrite, .imeValue, .irqClear);

  // HL only feeds the bank's own address mux
  registerBank regs0 (.iClock, .rstN, .regWrite, .incPc(uOp.incPc), .flowEnable, .pcLoad,
                      .addrSelLoad, .addrSel, .readStrobe, .srcSel, .srcData, .accData,
                      .hlPair(), .mcuAddr(oMcuAddr), .mcuData(oMcuData),
                      .readRequest(oMcuReadRequest));

  interruptController intc0 (.iClock, .rstN, .iInterruptRequests, .imeWrite, .imeValue,
                             .irqClear, .irqTaken, .irqVector);

endmodule

/* rtl/interruptController.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module interruptController
(
  input  logic             iClock,
  input  logic             rstN,
  input  cpuDataPkg::irqT  iInterruptRequests,
  input  logic             imeWrite,
  input  logic             imeValue,
  input  logic             irqClear,
  output logic             irqTaken,
  output cpuDataPkg::wordT irqVector
);
  import cpuDataPkg::*;

  irqT  pending;   // Set-only request latch
  logic ime;

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      pending <= '0;
      ime     <= 1'b0;
    end
    else
    begin
      if (irqClear)
        pending <= iInterruptRequests;   // Requests arriving now survive the clear
      else
        pending <= pending | iInterruptRequests;
      if (imeWrite)
        ime <= imeValue;
    end
  end

  // Lowest set bit wins
  always_comb
  begin
    if (pending[0])
      irqVector = `INT_VEC_VBLANK;
    else if (pending[1])
      irqVector = `INT_VEC_LCD;
    else if (pending[2])
      irqVector = `INT_VEC_TIMER;
    else
      irqVector = `INT_VEC_JOYPAD;
  end

  assign irqTaken = ime & (|pending);

endmodule

/* rtl/microOpExecute.sv */
`timescale 1ns/1ps

module microOpExecute
(
  input  cpuMicroPkg::microOpT uOp,
  input  logic                 flowEnable,
  input  cpuDataPkg::byteT     opcode,
  input  cpuDataPkg::byteT     iMcuData,
  input  cpuDataPkg::byteT     srcData,
  input  cpuDataPkg::byteT     accData,
  input  logic                 irqTaken,
  input  cpuDataPkg::wordT     irqVector,
  output cpuMicroPkg::regSelT  srcSel,
  output cpuDataPkg::regWriteT regWrite,
  output cpuDataPkg::pcLoadT   pcLoad,
  output logic                 addrSelLoad,
  output cpuMicroPkg::regSelT  addrSel,
  output logic                 memWrite,
  output logic                 readStrobe,
  output logic                 imeWrite,
  output logic                 imeValue,
  output logic                 irqClear
);
  import cpuMicroPkg::*;
  import cpuDataPkg::*;

  regSelT     operand;     // Operand with opcode fields resolved
  logic [2:0] aluDst;
  byteT       aluResult;

  // --------------------
  // Operand resolution
  always_comb
  begin
    case (uOp.operand)
      regOpSrc: operand = regSelT'({1'b0, opcode[2:0]});
      regOpDst: operand = regSelT'({1'b0, opcode[5:3]});
      default:  operand = uOp.operand;
    endcase
  end

  assign srcSel  = operand;
  assign addrSel = operand;

  always_comb
  begin
    case (opcode[7:3])
      5'b10100: aluResult = accData & srcData;   // AND r
      5'b10101: aluResult = accData ^ srcData;   // XOR r
      default:  aluResult = srcData;             // LD r,r'
    endcase
  end

  // Logic ops always land in A
  assign aluDst = (opcode[7:6] == 2'b01) ? opcode[5:3] : 3'(regA);

  // --------------------
  // Command decode
  always_comb
  begin
    regWrite    = '0;
    pcLoad      = '0;
    addrSelLoad = 1'b0;
    memWrite    = 1'b0;
    readStrobe  = 1'b0;
    imeWrite    = 1'b0;
    irqClear    = 1'b0;
    case (uOp.cmd)
      cmdSma:
      begin
        addrSelLoad = flowEnable;
        readStrobe  = flowEnable;   // Request goes out next cycle
      end
      cmdSrm:
      begin
        regWrite.we      = flowEnable;
        regWrite.regCode = operand[2:0];
        regWrite.data    = iMcuData;
      end
      cmdSmw: memWrite = flowEnable;
      cmdAluOp:
      begin
        regWrite.we      = flowEnable;
        regWrite.regCode = aluDst;
        regWrite.data    = aluResult;
      end
      cmdJint:
      begin
        // Redirect only, nothing is pushed
        pcLoad.load   = flowEnable & irqTaken;
        pcLoad.target = irqVector;
        irqClear      = flowEnable & irqTaken;
      end
      cmdSeti, cmdCeti: imeWrite = flowEnable;
      default: ;
    endcase
  end

  assign imeValue = (uOp.cmd == cmdSeti);

endmodule

/* rtl/microSequencer.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module microSequencer
(
  input  logic             iClock,
  input  logic             rstN,
  input  cpuDataPkg::byteT iMcuData,
  input  logic             endFlow,
  output cpuMicroPkg::uPcT uPc,
  output logic             flowEnable,
  output cpuDataPkg::byteT opcode
);
  import cpuMicroPkg::*;
  import cpuDataPkg::*;

  seqStateT state;

  // Opcode to flow entry, anything unsupported runs as NOP
  function automatic uPcT flowStart(input byteT op);
    uPcT start;
    start = `FLOW_NOP;
    if (op[7:6] == 2'b00 && op[2:0] == 3'd6 && op[5:3] != 3'd6)
      start = `FLOW_LDRN;                           // LD r,n
    else if (op[7:6] == 2'b01 && op[2:0] != 3'd6)
      start = (op[5:3] == 3'd6) ? `FLOW_STHL : `FLOW_ALU;
    else if (op[7:4] == 4'hA && op[2:0] != 3'd6)
      start = `FLOW_ALU;                            // AND r, XOR r
    else if (op == 8'hFB)
      start = `FLOW_EI;
    else if (op == 8'hF3)
      start = `FLOW_DI;
    return start;
  endfunction

  // --------------------
  // Flow state machine
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= afterReset;
      uPc   <= '0;
    end
    else
    begin
      case (state)
        afterReset: state <= startFlow;
        startFlow:
        begin
          uPc   <= flowStart(iMcuData);
          state <= runFlow;
        end
        runFlow:
        begin
          uPc <= uPc + uPcT'(1);   // One micro-op per cycle
          if (endFlow)
            state <= cpuMicroPkg::endFlow;
        end
        default: state <= startFlow;
      endcase
    end
  end

  // The bus moves on to the operand during LD r,n
  always_ff @(posedge iClock)
  begin
    if (state == startFlow)
      opcode <= iMcuData;
  end

  assign flowEnable = (state == runFlow);

endmodule

/* rtl/microcodeRom.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module microcodeRom
(
  input  cpuMicroPkg::uPcT     uPc,
  output cpuMicroPkg::microOpT uOp
);
  import cpuMicroPkg::*;

  // Shared ending of every flow
  localparam microOpT JintOp  = '{cmdJint, regPc, 1'b0, 1'b0};
  localparam microOpT FetchOp = '{cmdSma, regPc, 1'b0, 1'b1};

  function automatic microOpT mkOp(input uOpCmdT cmd, input regSelT sel, input logic inc);
    microOpT op;
    op.cmd     = cmd;
    op.operand = sel;
    op.incPc   = inc;
    op.endFlow = 1'b0;
    return op;
  endfunction

  always_comb
  begin
    case (uPc)
      // --------------------
      `FLOW_NOP:          uOp = mkOp(cmdNop, regPc, 1'b1);
      `FLOW_NOP + 6'd1:   uOp = JintOp;
      `FLOW_NOP + 6'd2:   uOp = FetchOp;

      // Skip the opcode, then take the immediate from the bus
      `FLOW_LDRN:         uOp = mkOp(cmdNop, regPc, 1'b1);
      `FLOW_LDRN + 6'd1:  uOp = mkOp(cmdSrm, regOpDst, 1'b1);
      `FLOW_LDRN + 6'd2:  uOp = JintOp;
      `FLOW_LDRN + 6'd3:  uOp = FetchOp;

      `FLOW_ALU:          uOp = mkOp(cmdAluOp, regOpSrc, 1'b1);
      `FLOW_ALU + 6'd1:   uOp = JintOp;
      `FLOW_ALU + 6'd2:   uOp = FetchOp;

      // LD (HL),r
      `FLOW_STHL:         uOp = mkOp(cmdSma, regHl, 1'b1);
      `FLOW_STHL + 6'd1:  uOp = mkOp(cmdSmw, regOpSrc, 1'b0);
      `FLOW_STHL + 6'd2:  uOp = JintOp;
      `FLOW_STHL + 6'd3:  uOp = FetchOp;

      // --------------------
      `FLOW_EI:           uOp = mkOp(cmdSeti, regPc, 1'b1);
      `FLOW_EI + 6'd1:    uOp = JintOp;     // Already sees interrupts enabled
      `FLOW_EI + 6'd2:    uOp = FetchOp;
      `FLOW_DI:           uOp = mkOp(cmdCeti, regPc, 1'b1);
      `FLOW_DI + 6'd1:    uOp = JintOp;
      `FLOW_DI + 6'd2:    uOp = FetchOp;

      default:            uOp = '{cmdNop, regPc, 1'b0, 1'b1};
    endcase
  end

endmodule

/* rtl/registerBank.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module registerBank
(
  input  logic                 iClock,
  input  logic                 rstN,
  input  cpuDataPkg::regWriteT regWrite,
  input  logic                 incPc,
  input  logic                 flowEnable,
  input  cpuDataPkg::pcLoadT   pcLoad,
  input  logic                 addrSelLoad,
  input  cpuMicroPkg::regSelT  addrSel,
  input  logic                 readStrobe,
  input  cpuMicroPkg::regSelT  srcSel,
  output cpuDataPkg::byteT     srcData,
  output cpuDataPkg::byteT     accData,
  output cpuDataPkg::wordT     hlPair,
  output cpuDataPkg::wordT     mcuAddr,
  output cpuDataPkg::byteT     mcuData,
  output logic                 readRequest
);
  import cpuMicroPkg::*;
  import cpuDataPkg::*;

  byteT   gpr [8];    // Indexed by register code, slot 6 is (HL) and stays empty
  wordT   pc;
  regSelT addrSelQ;   // Drives the address mux

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        gpr[i] <= '0;
    end
    else if (regWrite.we && regWrite.regCode != 3'd6)
      gpr[regWrite.regCode] <= regWrite.data;
  end

  // --------------------
  // PC, address select and read request
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      pc          <= `RESET_PC;
      addrSelQ    <= regPc;
      readRequest <= 1'b0;
    end
    else
    begin
      if (pcLoad.load)
        pc <= pcLoad.target;   // Vector wins over the increment
      else if (incPc && flowEnable)
        pc <= pc + 16'd1;
      if (addrSelLoad)
        addrSelQ <= addrSel;
      readRequest <= readStrobe;
    end
  end

  always_comb
  begin
    case (srcSel)
      regB, regC, regD, regE, regH, regL, regA: srcData = gpr[srcSel[2:0]];
      default: srcData = '0;
    endcase
  end

  assign accData = gpr[7];
  assign hlPair  = {gpr[4], gpr[5]};
  assign mcuData = srcData;   // Store data follows the resolved source

  always_comb
  begin
    case (addrSelQ)
      regHl: mcuAddr = hlPair;
      regB, regC, regD, regE, regH, regL, regA: mcuAddr = wordT'(gpr[addrSelQ[2:0]]);
      default: mcuAddr = pc;   // Live PC, so fetches track increments
    endcase
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f src.f -o cpuSim \
  && ./obj_dir/cpuSim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* src.f */
+incdir+rtl
rtl/cpuMicroPkg.sv
rtl/cpuDataPkg.sv
rtl/microSequencer.sv
rtl/microcodeRom.sv
rtl/microOpExecute.sv
rtl/registerBank.sv
rtl/interruptController.sv
rtl/dzCpu.sv
verification/cpuTb_sva.sv
verification/cpuTb.sv

/* verification/cpuTb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb;
  import cpuDataPkg::*;

  localparam int NumInstr      = 300;
  localparam int NumRunTests   = 4;
  localparam int TimeoutCycles = NumRunTests * (NumInstr * 6 + 10) + 20;

  typedef struct packed
  {
    logic isWrite;
    logic isFetch;     // Opcode fetch, closes one instruction
    wordT addr;
    byteT data;
  } busEventT;

  logic iClock;
  logic rstN = 1'b0;
  byteT iMcuData;
  byteT oMcuData;
  wordT oMcuAddr;
  logic oMcuReadRequest;
  logic oMcuWe;
  irqT  iInterruptRequests = '0;

  byteT        mem [65536];
  logic [31:0] rngState = 32'hfd51ed11;
  busEventT    expQ [$];
  irqT         pulseQ [$];   // One entry per store, zero when nothing is pulsed

  // Instruction level model state
  byteT mRegs [8];
  wordT mPc;
  logic mIme;
  irqT  mPending;

  logic active = 1'b0;
  logic pulseMode;
  int   instrDone;
  int   errors;
  int   testErrors;
  int   checks;
  int   cycleCount;

  dzCpu dut0 (.iClock, .rstN, .iMcuData, .oMcuData, .oMcuAddr, .oMcuReadRequest, .oMcuWe,
              .iInterruptRequests);

  assign iMcuData = mem[oMcuAddr];

  initial
  begin
    iClock = 1'b0;
    forever #20 iClock = ~iClock;
  end

  always @(posedge iClock)
  begin
    if (oMcuWe)
      mem[oMcuAddr] <= oMcuData;
  end

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // Any register but the (HL) slot
  function automatic logic [2:0] pickReg();
    logic [2:0] r;
    r = 3'(nextRand() % 7);
    if (r == 3'd6)
      r = 3'd7;
    return r;
  endfunction

  function automatic wordT vectorOf(input irqT p);
    if (p[0])
      return `INT_VEC_VBLANK;
    else if (p[1])
      return `INT_VEC_LCD;
    else if (p[2])
      return `INT_VEC_TIMER;
    else
      return `INT_VEC_JOYPAD;
  endfunction

  task automatic noteError();
    errors++;
    testErrors++;
  endtask

  // --------------------
  // Program generation
  task automatic fillProgram(input int mix);
    int   addr;
    int   kind;
    byteT b;
    addr = 0;
    while (addr < 65536)
    begin
      kind = int'(nextRand() % 10);
      case (kind)
        0, 1:    b = {2'b00, pickReg(), 3'b110};        // LD r,n
        2, 3:    b = {2'b01, pickReg(), pickReg()};
        4, 5:    b = {2'b01, 3'b110, pickReg()};        // LD (HL),r
        6:       b = 8'h00;
        7:       b = (mix >= 1) ? {5'b10100, pickReg()} : {2'b01, pickReg(), pickReg()};
        8:       b = (mix >= 1) ? {5'b10101, pickReg()} : {2'b01, 3'b110, pickReg()};
        default:
        begin
          if (mix == 2)
            b = 8'hFB;
          else if (mix == 3)
            b = (nextRand() % 3 == 0) ? 8'hFB : 8'hF3;  // DI more often than EI
          else
            b = 8'h00;
        end
      endcase
      mem[addr] = b;
      addr++;
      if (kind <= 1 && addr < 65536)
      begin
        mem[addr] = byteT'(nextRand());   // Immediate
        addr++;
      end
    end
  endtask

  // --------------------
  // Reference model, one instruction per call
  task automatic stepModel();
    byteT       op;
    logic [2:0] dst;
    logic [2:0] src;
    wordT       hl;
    wordT       nextPc;
    irqT        pulse;
    op     = mem[mPc];
    dst    = op[5:3];
    src    = op[2:0];
    nextPc = mPc + 16'd1;
    if (op[7:6] == 2'b00 && src == 3'd6 && dst != 3'd6)
    begin
      mRegs[dst] = mem[mPc + 16'd1];
      nextPc     = mPc + 16'd2;
    end
    else if (op[7:6] == 2'b01 && src != 3'd6)
    begin
      if (dst == 3'd6)
      begin
        hl = {mRegs[4], mRegs[5]};
        expQ.push_back('{1'b0, 1'b0, hl, 8'h00});
        expQ.push_back('{1'b1, 1'b0, hl, mRegs[src]});
        pulse = '0;
        if (pulseMode && nextRand() % 2 == 0)
          pulse = irqT'(nextRand() % 15 + 1);
        pulseQ.push_back(pulse);
        mPending |= pulse;
      end
      else
        mRegs[dst] = mRegs[src];
    end
    else if (op[7:4] == 4'hA && src != 3'd6)
      mRegs[7] = op[3] ? (mRegs[7] ^ mRegs[src]) : (mRegs[7] & mRegs[src]);
    else if (op == 8'hFB)
      mIme = 1'b1;
    else if (op == 8'hF3)
      mIme = 1'b0;
    if (mIme && mPending != '0)
    begin
      nextPc   = vectorOf(mPending);   // Redirect only
      mPending = '0;
    end
    expQ.push_back('{1'b0, 1'b1, nextPc, 8'h00});
    mPc = nextPc;
  endtask

  // --------------------
  // Bus checks
  task automatic checkRead();
    busEventT ev;
    checks++;
    if (expQ.size() == 0)
    begin
      $display("Error at %0t: read request at %h when no bus event was expected",
               $time, oMcuAddr);
      noteError();
    end
    else
    begin
      ev = expQ.pop_front();
      if (ev.isWrite)
      begin
        $display("Error at %0t: read request at %h where a write was expected", $time, oMcuAddr);
        noteError();
      end
      else if (oMcuAddr !== ev.addr)
      begin
        $display("** Error at %0t: oMcuAddr = %h, expected %h", $time, oMcuAddr, ev.addr);
        noteError();
      end
      if (!ev.isWrite && ev.isFetch)
      begin
        instrDone++;
        if (instrDone >= NumInstr)
          active = 1'b0;
        else
          stepModel();
      end
    end
  endtask

  task automatic checkWrite();
    busEventT ev;
    checks++;
    if (expQ.size() == 0 || !expQ[0].isWrite)
    begin
      $display("Error at %0t: memory write at %h that the model did not expect", $time, oMcuAddr);
      noteError();
    end
    else
    begin
      ev = expQ.pop_front();
      if (oMcuAddr !== ev.addr)
      begin
        $display("** Error at %0t: oMcuAddr = %h, expected %h", $time, oMcuAddr, ev.addr);
        noteError();
      end
      if (oMcuData !== ev.data)
      begin
        $display("** Error at %0t: oMcuData = %h, expected %h", $time, oMcuData, ev.data);
        noteError();
      end
    end
  endtask

  // Checks, then request pulses, all on the falling edge
  always @(negedge iClock)
  begin
    if (active && oMcuReadRequest)
      checkRead();
    if (active && oMcuWe)
      checkWrite();
    if (active && oMcuWe && pulseQ.size() > 0)
      iInterruptRequests <= pulseQ.pop_front();
    else
      iInterruptRequests <= '0;
  end

  task automatic checkIdleBus();
    checks++;
    if (oMcuWe !== 1'b0)
    begin
      $display("** Error at %0t: oMcuWe = %b, expected 0", $time, oMcuWe);
      noteError();
    end
    if (oMcuReadRequest !== 1'b0)
    begin
      $display("** Error at %0t: oMcuReadRequest = %b, expected 0", $time, oMcuReadRequest);
      noteError();
    end
    if (oMcuAddr !== `RESET_PC)
    begin
      $display("** Error at %0t: oMcuAddr = %h, expected %h", $time, oMcuAddr, `RESET_PC);
      noteError();
    end
  endtask

  task automatic runResetTest();
    testErrors = 0;
    @(negedge iClock);
    rstN = 1'b0;
    repeat (3)
    begin
      @(negedge iClock);
      checkIdleBus();
    end
    rstN = 1'b1;
    @(negedge iClock);
    checkIdleBus();   // First cycle after reset
    $display("Test reset: %0d errors", testErrors);
  endtask

  task automatic runProgram(input string name, input int mix, input logic pulses);
    testErrors = 0;
    @(negedge iClock);
    rstN = 1'b0;
    fillProgram(mix);
    expQ.delete();
    pulseQ.delete();
    for (int i = 0; i < 8; i++)
      mRegs[i] = '0;
    mPc       = `RESET_PC;
    mIme      = 1'b0;
    mPending  = '0;
    pulseMode = pulses;
    instrDone = 0;
    stepModel();     // First fetch at the reset PC has no read pulse
    repeat (3) @(negedge iClock);
    rstN = 1'b1;
    @(negedge iClock);
    active = 1'b1;
    while (active)
      @(negedge iClock);
    $display("Test %s: %0d instructions, %0d errors", name, instrDone, testErrors);
  endtask

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge iClock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the CPU stopped producing bus events", cycleCount);
    $display("Checks failed");
    $finish;
  end

  // --------------------
  initial
  begin
    errors = 0;
    checks = 0;
    runResetTest();
    runProgram("loads and stores", 0, 1'b0);
    runProgram("logic operations", 1, 1'b0);
    runProgram("interrupt priority", 2, 1'b1);
    runProgram("pending while disabled", 3, 1'b1);
    $display("5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* verification/cpuTb_sva.sv */
`timescale 1ns/1ps

module busSeqAssertions
(
  input logic                  iClock,
  input logic                  rstN,
  input cpuMicroPkg::seqStateT state,
  input logic                  readRequest,
  input logic                  memWrite
);
  import cpuMicroPkg::*;

  // One-cycle read request
  readPulse: assert property (@(posedge iClock) disable iff (!rstN)
    readRequest |=> !readRequest)
    else $error("read request held for two cycles");

  writeInFlow: assert property (@(posedge iClock) disable iff (!rstN)
    memWrite |-> state == runFlow)
    else $error("memory write outside runFlow");

  // --------------------
  flowRestart: assert property (@(posedge iClock) disable iff (!rstN)
    state == endFlow |=> state == startFlow)
    else $error("endFlow not followed by startFlow");

endmodule

bind dzCpu busSeqAssertions sva0 (.iClock, .rstN, .state(seq0.state),
                                  .readRequest(oMcuReadRequest), .memWrite(oMcuWe));
